//--- tb/raster_tests.txt
// columns: command_x_y_depth_color in hex. command 0 sends a fragment,
// 1 reads back once the writer is idle, 2 reads back at once, f ends the list.
// after reset every pixel is far and black.
1_0_0_ffff_00
1_7_7_ffff_00
1_3_5_ffff_00
// a first fragment sets its pixel only.
0_3_4_1000_2a
1_3_4_1000_2a
1_2_4_ffff_00
1_4_4_ffff_00
1_3_3_ffff_00
// equal and farther fragments are rejected.
0_3_4_1000_55
0_3_4_2000_66
1_3_4_1000_2a
// a nearer fragment wins, corners check the address arithmetic.
0_3_4_0800_77
1_3_4_0800_77
0_0_0_0010_11
0_7_7_0020_22
1_0_0_0010_11
1_7_7_0020_22
1_1_0_ffff_00
1_6_7_ffff_00
// streaming at (5,2) with host reads of untouched pixels in between.
0_5_2_3000_a1
0_5_2_4000_a2
2_0_0_0010_11
0_5_2_2000_a3
0_5_2_2500_a4
2_3_4_0800_77
0_5_2_1800_a5
2_7_7_0020_22
0_5_2_1800_a6
0_5_2_1900_a7
2_2_4_ffff_00
1_5_2_1800_a5
f_0_0_0000_00

//--- tb.f
source/raster_pkg.sv
source/mem_bank.sv
source/fragment_writer.sv
source/bus_router.sv
source/raster_backend.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f tb.f --top-module tb_top -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"

//--- tb/tb_top.sv
`default_nettype none

module tb_top import raster_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCREEN_W        = 8;
    localparam int SCREEN_H        = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int MAX_TESTS       = 64;
    localparam int CYCLES_PER_TEST = 80;

    logic                   clk;
    logic                   nrst;
    logic                   frag_valid;
    logic [SC_WIDTH-1:0]    frag_x;
    logic [SC_WIDTH-1:0]    frag_y;
    logic [WORD_WIDTH-1:0]  frag_depth;
    logic [COLOR_WIDTH-1:0] frag_color;
    logic                   frag_ready;
    logic                   host_req;
    logic [ADDR_WIDTH-1:0]  host_addr;
    logic                   host_ack;
    logic [WORD_WIDTH-1:0]  host_rdata;

    logic                   read_pending;
    logic [WORD_WIDTH-1:0]  exp_data;
    logic                   test_done;
    logic [SC_WIDTH-1:0]    test_x;
    logic [SC_WIDTH-1:0]    test_y;
    logic                   summary_req;
    logic [31:0]            error_count;

    // one entry per line: command, x, y, depth, color.
    logic [35:0] tests [MAX_TESTS];
    int          n_tests     = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          tb_errors   = 0;

    tb_clock #(
        .HALF_PERIOD  (2),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_tb_clock (
        .clk_o  (clk),
        .nrst_o (nrst)
    );

    raster_backend #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) i_raster_backend (
        .clk_i        (clk),
        .nrst_i       (nrst),
        .frag_valid_i (frag_valid),
        .frag_x_i     (frag_x),
        .frag_y_i     (frag_y),
        .frag_depth_i (frag_depth),
        .frag_color_i (frag_color),
        .frag_ready_o (frag_ready),
        .host_req_i   (host_req),
        .host_addr_i  (host_addr),
        .host_ack_o   (host_ack),
        .host_rdata_o (host_rdata)
    );

    tb_checker i_tb_checker (
        .clk_i          (clk),
        .nrst_i         (nrst),
        .frag_valid_i   (frag_valid),
        .frag_ready_i   (frag_ready),
        .host_ack_i     (host_ack),
        .host_rdata_i   (host_rdata),
        .host_addr_i    (host_addr),
        .read_pending_i (read_pending),
        .exp_data_i     (exp_data),
        .test_done_i    (test_done),
        .test_x_i       (test_x),
        .test_y_i       (test_y),
        .summary_req_i  (summary_req),
        .error_count_o  (error_count)
    );

    // depth words sit above DEPTH_BASE, four bytes per pixel.
    function automatic logic [ADDR_WIDTH-1:0] depth_word_address(
        input logic [SC_WIDTH-1:0] x,
        input logic [SC_WIDTH-1:0] y
    );
        return DEPTH_BASE + ADDR_WIDTH'(4 * (int'(y) * SCREEN_W + int'(x)));
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] color_byte_address(
        input logic [SC_WIDTH-1:0] x,
        input logic [SC_WIDTH-1:0] y
    );
        return ADDR_WIDTH'(int'(y) * SCREEN_W + int'(x));
    endfunction

    // all tasks start and end on a falling edge.
    task automatic send_fragment(
        input logic [SC_WIDTH-1:0]    x,
        input logic [SC_WIDTH-1:0]    y,
        input logic [WORD_WIDTH-1:0]  depth,
        input logic [COLOR_WIDTH-1:0] color
    );
        frag_valid = 1'b1;
        frag_x     = x;
        frag_y     = y;
        frag_depth = depth;
        frag_color = color;
        while (!frag_ready) @(negedge clk);
        @(negedge clk);
        frag_valid = 1'b0;
    endtask

    task automatic wait_writer_idle();
        while (!frag_ready) @(negedge clk);
    endtask

    task automatic host_read(
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [WORD_WIDTH-1:0] expected
    );
        exp_data     = expected;
        host_addr    = addr;
        host_req     = 1'b1;
        read_pending = 1'b1;
        @(negedge clk);
        while (!host_ack) @(negedge clk);
        @(negedge clk);
        host_req     = 1'b0;
        read_pending = 1'b0;
        // req stays low for a full cycle before the next read.
        @(negedge clk);
    endtask

    task automatic read_back_pixel(
        input logic [SC_WIDTH-1:0]    x,
        input logic [SC_WIDTH-1:0]    y,
        input logic [WORD_WIDTH-1:0]  depth,
        input logic [COLOR_WIDTH-1:0] color
    );
        test_x = x;
        test_y = y;
        host_read(depth_word_address(x, y), depth);
        host_read(color_byte_address(x, y), {{(WORD_WIDTH - COLOR_WIDTH){1'b0}}, color});
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic [35:0] entry;
        int          gap;

        frag_valid   = 1'b0;
        frag_x       = '0;
        frag_y       = '0;
        frag_depth   = '0;
        frag_color   = '0;
        host_req     = 1'b0;
        host_addr    = '0;
        read_pending = 1'b0;
        exp_data     = '0;
        test_done    = 1'b0;
        test_x       = '0;
        test_y       = '0;
        summary_req  = 1'b0;
        void'($urandom(32'hd4fe_e603));

        $readmemh("tb/raster_tests.txt", tests);
        while (n_tests < MAX_TESTS && tests[n_tests][35:32] != 4'hf) begin
            n_tests++;
        end
        if (n_tests == MAX_TESTS) begin
            $display("the tests file has no end marker within %0d entries", MAX_TESTS);
            tb_errors++;
        end
        cycle_limit = CYCLES_PER_TEST * n_tests + RESET_CYCLES;

        wait (nrst);
        @(negedge clk);

        for (int i = 0; i < n_tests; i++) begin
            entry = tests[i];
            case (entry[35:32])
                4'h0: send_fragment(entry[31:28], entry[27:24], entry[23:8], entry[7:0]);
                4'h1: begin
                    wait_writer_idle();
                    read_back_pixel(entry[31:28], entry[27:24], entry[23:8], entry[7:0]);
                end
                // read at once, while the writer may still be busy.
                4'h2: read_back_pixel(entry[31:28], entry[27:24], entry[23:8], entry[7:0]);
                default: begin
                    $display("entry %0d of the tests file has an unknown command %h",
                             i, entry[35:32]);
                    tb_errors++;
                end
            endcase
            gap = $urandom % 6;
            repeat (gap) @(negedge clk);
        end

        wait_writer_idle();
        summary_req = 1'b1;
        @(negedge clk);
        @(negedge clk);
        if (error_count == 0 && tb_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_checker.sv
`default_nettype none

module tb_checker import raster_pkg::*; (
    input  wire                    clk_i,
    input  wire                    nrst_i,

    input  wire                    frag_valid_i,
    input  wire                    frag_ready_i,

    input  wire                    host_ack_i,
    input  wire  [WORD_WIDTH-1:0]  host_rdata_i,
    input  wire  [ADDR_WIDTH-1:0]  host_addr_i,

    input  wire                    read_pending_i,
    input  wire  [WORD_WIDTH-1:0]  exp_data_i,
    input  wire                    test_done_i,
    input  wire  [SC_WIDTH-1:0]    test_x_i,
    input  wire  [SC_WIDTH-1:0]    test_y_i,
    input  wire                    summary_req_i,
    output logic [31:0]            error_count_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int errors          = 0;
    int test_errors     = 0;
    int acks_in_test    = 0;
    int tests_run       = 0;
    int tests_failed    = 0;
    bit summary_printed = 1'b0;
    bit prev_ready      = 1'b1;
    bit prev_valid      = 1'b0;

    assign error_count_o = errors;

    // outputs are sampled at the rising edge, where they hold the values
    // set by the previous edge.
    always @(posedge clk_i) begin
        if (nrst_i) begin
            // the writer is ready out of reset and only leaves idle on a transfer.
            if (prev_ready && !prev_valid && !frag_ready_i) begin
                $display("Mismatch frag_ready_o: expected %h, got %h", 1'b1, frag_ready_i);
                errors++;
            end
            prev_ready = frag_ready_i;
            prev_valid = frag_valid_i;

            if (host_ack_i) begin
                acks_in_test++;
                if (!read_pending_i) begin
                    $display("host_ack_o went high while no host read was pending");
                    errors++;
                    test_errors++;
                end else if (host_rdata_i !== exp_data_i) begin
                    $display("Mismatch host_rdata_o at address %h: expected %h, got %h",
                             host_addr_i, exp_data_i, host_rdata_i);
                    errors++;
                    test_errors++;
                end
            end

            // each read-back is one depth read and one color read.
            if (test_done_i) begin
                if (acks_in_test != 2) begin
                    $display("read-back at pixel (%0d,%0d) saw %0d host acknowledges, not two",
                             test_x_i, test_y_i, acks_in_test);
                    errors++;
                    test_errors++;
                end
                tests_run++;
                if (test_errors == 0) begin
                    $display("read-back %0d at pixel (%0d,%0d): ok",
                             tests_run, test_x_i, test_y_i);
                end else begin
                    $display("read-back %0d at pixel (%0d,%0d): FAILED",
                             tests_run, test_x_i, test_y_i);
                    tests_failed++;
                end
                test_errors  = 0;
                acks_in_test = 0;
            end

            if (summary_req_i && !summary_printed) begin
                $display("summary: %0d read-backs, %0d passed, %0d failed, %0d errors",
                         tests_run, tests_run - tests_failed, tests_failed, errors);
                summary_printed = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic nrst_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset is released on a falling edge, away from the active edge.
    initial begin
        nrst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        nrst_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- source/raster_backend.sv
`default_nettype none

module raster_backend import raster_pkg::*; #(
    parameter int SCREEN_W = 8,
    parameter int SCREEN_H = 8
) (
    input  wire                     clk_i,
    input  wire                     nrst_i,

    input  wire                     frag_valid_i,
    input  wire  [SC_WIDTH-1:0]     frag_x_i,
    input  wire  [SC_WIDTH-1:0]     frag_y_i,
    input  wire  [WORD_WIDTH-1:0]   frag_depth_i,
    input  wire  [COLOR_WIDTH-1:0]  frag_color_i,
    output logic                    frag_ready_o,

    input  wire                     host_req_i,
    input  wire  [ADDR_WIDTH-1:0]   host_addr_i,
    output logic                    host_ack_o,
    output logic [WORD_WIDTH-1:0]   host_rdata_o
);

    localparam int PIXELS = SCREEN_W * SCREEN_H;
    localparam int IDX_W  = $clog2(PIXELS);

    logic                   bus_req;
    bus_rw_e                bus_rw;
    logic [ADDR_WIDTH-1:0]  bus_addr;
    logic [WORD_WIDTH-1:0]  bus_wdata;
    logic                   bus_ack;
    logic [WORD_WIDTH-1:0]  bus_rdata;

    logic                   depth_en;
    logic                   depth_we;
    logic [IDX_W-1:0]       depth_index;
    depth_t                 depth_wdata;
    depth_t                 depth_rdata;

    logic                   color_en;
    logic                   color_we;
    logic [IDX_W-1:0]       color_index;
    color_t                 color_wdata;
    color_t                 color_rdata;

    fragment_writer #(
        .SCREEN_W(SCREEN_W),
        .SCREEN_H(SCREEN_H)
    ) i_fragment_writer (
        .clk_i        (clk_i),
        .nrst_i       (nrst_i),
        .frag_valid_i (frag_valid_i),
        .frag_x_i     (frag_x_i),
        .frag_y_i     (frag_y_i),
        .frag_depth_i (frag_depth_i),
        .frag_color_i (frag_color_i),
        .frag_ready_o (frag_ready_o),
        .bus_req_o    (bus_req),
        .bus_rw_o     (bus_rw),
        .bus_addr_o   (bus_addr),
        .bus_wdata_o  (bus_wdata),
        .bus_ack_i    (bus_ack),
        .bus_rdata_i  (bus_rdata)
    );

    bus_router #(
        .SCREEN_W(SCREEN_W),
        .SCREEN_H(SCREEN_H)
    ) i_bus_router (
        .clk_i         (clk_i),
        .nrst_i        (nrst_i),
        .wr_req_i      (bus_req),
        .wr_rw_i       (bus_rw),
        .wr_addr_i     (bus_addr),
        .wr_wdata_i    (bus_wdata),
        .wr_ack_o      (bus_ack),
        .wr_rdata_o    (bus_rdata),
        .host_req_i    (host_req_i),
        .host_addr_i   (host_addr_i),
        .host_ack_o    (host_ack_o),
        .host_rdata_o  (host_rdata_o),
        .depth_en_o    (depth_en),
        .depth_we_o    (depth_we),
        .depth_index_o (depth_index),
        .depth_wdata_o (depth_wdata),
        .depth_rdata_i (depth_rdata),
        .color_en_o    (color_en),
        .color_we_o    (color_we),
        .color_index_o (color_index),
        .color_wdata_o (color_wdata),
        .color_rdata_i (color_rdata)
    );

    // an empty depth buffer reads as the farthest possible depth.
    mem_bank #(
        .data_t (depth_t),
        .DEPTH  (PIXELS),
        .FILL   ({WORD_WIDTH{1'b1}})
    ) i_depth_bank (
        .clk_i   (clk_i),
        .nrst_i  (nrst_i),
        .en_i    (depth_en),
        .we_i    (depth_we),
        .index_i (depth_index),
        .wdata_i (depth_wdata),
        .rdata_o (depth_rdata)
    );

    mem_bank #(
        .data_t (color_t),
        .DEPTH  (PIXELS),
        .FILL   ({COLOR_WIDTH{1'b0}})
    ) i_color_bank (
        .clk_i   (clk_i),
        .nrst_i  (nrst_i),
        .en_i    (color_en),
        .we_i    (color_we),
        .index_i (color_index),
        .wdata_i (color_wdata),
        .rdata_o (color_rdata)
    );

endmodule

`default_nettype wire

//--- source/bus_router.sv
`default_nettype none

module bus_router import raster_pkg::*; #(
    parameter int SCREEN_W = 8,
    parameter int SCREEN_H = 8,
    localparam int IDX_W   = $clog2(SCREEN_W * SCREEN_H)
) (
    input  wire                     clk_i,
    input  wire                     nrst_i,

    input  wire                     wr_req_i,
    input  wire  bus_rw_e           wr_rw_i,
    input  wire  [ADDR_WIDTH-1:0]   wr_addr_i,
    input  wire  [WORD_WIDTH-1:0]   wr_wdata_i,
    output logic                    wr_ack_o,
    output logic [WORD_WIDTH-1:0]   wr_rdata_o,

    input  wire                     host_req_i,
    input  wire  [ADDR_WIDTH-1:0]   host_addr_i,
    output logic                    host_ack_o,
    output logic [WORD_WIDTH-1:0]   host_rdata_o,

    output logic                    depth_en_o,
    output logic                    depth_we_o,
    output logic [IDX_W-1:0]        depth_index_o,
    output logic [WORD_WIDTH-1:0]   depth_wdata_o,
    input  wire  [WORD_WIDTH-1:0]   depth_rdata_i,

    output logic                    color_en_o,
    output logic                    color_we_o,
    output logic [IDX_W-1:0]        color_index_o,
    output logic [COLOR_WIDTH-1:0]  color_wdata_o,
    input  wire  [COLOR_WIDTH-1:0]  color_rdata_i
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ACCESS,
        R_CAPTURE,
        R_HOLD
    } state_e;

    state_e state;

    logic                  grant_host;
    logic                  ack_q;
    logic [WORD_WIDTH-1:0] rdata_q;

    logic                  sel_req;
    bus_rw_e               sel_rw;
    logic [ADDR_WIDTH-1:0] sel_addr;
    logic [WORD_WIDTH-1:0] sel_wdata;
    logic                  sel_depth;
    logic [ADDR_WIDTH-1:0] depth_offset;
    logic                  bank_access;

    // the host port is read only.
    always_comb begin
        if (grant_host) begin
            sel_req   = host_req_i;
            sel_rw    = BUS_READ;
            sel_addr  = host_addr_i;
            sel_wdata = '0;
        end else begin
            sel_req   = wr_req_i;
            sel_rw    = wr_rw_i;
            sel_addr  = wr_addr_i;
            sel_wdata = wr_wdata_i;
        end
    end

    assign sel_depth    = (sel_addr >= DEPTH_BASE);
    assign depth_offset = sel_addr - DEPTH_BASE;
    assign bank_access  = (state == R_ACCESS);

    assign depth_en_o    = bank_access && sel_depth;
    assign depth_we_o    = depth_en_o && (sel_rw == BUS_WRITE);
    assign depth_index_o = depth_offset[IDX_W+1:2];
    assign depth_wdata_o = sel_wdata;

    assign color_en_o    = bank_access && !sel_depth;
    assign color_we_o    = color_en_o && (sel_rw == BUS_WRITE);
    assign color_index_o = sel_addr[IDX_W-1:0];
    assign color_wdata_o = sel_wdata[COLOR_WIDTH-1:0];

    // the grant stays put until the granted requester drops req.
    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state      <= R_IDLE;
            grant_host <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (wr_req_i) begin
                        grant_host <= 1'b0;
                        state      <= R_ACCESS;
                    end else if (host_req_i) begin
                        grant_host <= 1'b1;
                        state      <= R_ACCESS;
                    end
                end
                R_ACCESS: begin
                    state <= R_CAPTURE;
                end
                R_CAPTURE: begin
                    ack_q <= 1'b1;
                    state <= R_HOLD;
                end
                R_HOLD: begin
                    ack_q <= 1'b0;
                    if (!sel_req) begin
                        state <= R_IDLE;
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    // color reads come back zero-extended to a full word.
    always_ff @(posedge clk_i) begin
        if (state == R_CAPTURE) begin
            if (sel_depth) begin
                rdata_q <= depth_rdata_i;
            end else begin
                rdata_q <= {{(WORD_WIDTH - COLOR_WIDTH){1'b0}}, color_rdata_i};
            end
        end
    end

    assign wr_ack_o     = ack_q && !grant_host;
    assign host_ack_o   = ack_q && grant_host;
    assign wr_rdata_o   = rdata_q;
    assign host_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- source/fragment_writer.sv
`default_nettype none

module fragment_writer import raster_pkg::*; #(
    parameter int SCREEN_W = 8,
    parameter int SCREEN_H = 8
) (
    input  wire                     clk_i,
    input  wire                     nrst_i,

    input  wire                     frag_valid_i,
    input  wire  [SC_WIDTH-1:0]     frag_x_i,
    input  wire  [SC_WIDTH-1:0]     frag_y_i,
    input  wire  [WORD_WIDTH-1:0]   frag_depth_i,
    input  wire  [COLOR_WIDTH-1:0]  frag_color_i,
    output logic                    frag_ready_o,

    output logic                    bus_req_o,
    output bus_rw_e                 bus_rw_o,
    output logic [ADDR_WIDTH-1:0]   bus_addr_o,
    output logic [WORD_WIDTH-1:0]   bus_wdata_o,
    input  wire                     bus_ack_i,
    input  wire  [WORD_WIDTH-1:0]   bus_rdata_i
);

    localparam int IDX_W = $clog2(SCREEN_W * SCREEN_H);

    // each bus transaction has an ACK state (waiting for the pulse) and
    // an END state (waiting for ack to fall before req is dropped).
    typedef enum logic [3:0] {
        S_IDLE,
        S_RD_ACK,
        S_RD_END,
        S_CHECK,
        S_WD_ACK,
        S_WD_END,
        S_WC_START,
        S_WC_ACK,
        S_WC_END
    } state_e;

    state_e state;

    logic [IDX_W-1:0]       in_index;
    logic [IDX_W-1:0]       idx_q;
    logic [WORD_WIDTH-1:0]  depth_q;
    logic [COLOR_WIDTH-1:0] color_q;
    logic [WORD_WIDTH-1:0]  stored_q;

    // byte address of the depth word of a pixel.
    function automatic logic [ADDR_WIDTH-1:0] depth_addr(input logic [IDX_W-1:0] idx);
        return DEPTH_BASE + (ADDR_WIDTH'(idx) << 2);
    endfunction

    assign in_index = IDX_W'(frag_y_i * SCREEN_W + frag_x_i);

    assign frag_ready_o = (state == S_IDLE);

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state     <= S_IDLE;
            bus_req_o <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (frag_valid_i) begin
                        bus_req_o <= 1'b1;
                        state     <= S_RD_ACK;
                    end
                end
                S_RD_ACK: begin
                    if (bus_ack_i) begin
                        state <= S_RD_END;
                    end
                end
                S_RD_END: begin
                    if (!bus_ack_i) begin
                        bus_req_o <= 1'b0;
                        state     <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    // the new fragment must be strictly nearer to win.
                    if (stored_q > depth_q) begin
                        bus_req_o <= 1'b1;
                        state     <= S_WD_ACK;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_WD_ACK: begin
                    if (bus_ack_i) begin
                        state <= S_WD_END;
                    end
                end
                S_WD_END: begin
                    if (!bus_ack_i) begin
                        bus_req_o <= 1'b0;
                        state     <= S_WC_START;
                    end
                end
                S_WC_START: begin
                    bus_req_o <= 1'b1;
                    state     <= S_WC_ACK;
                end
                S_WC_ACK: begin
                    if (bus_ack_i) begin
                        state <= S_WC_END;
                    end
                end
                S_WC_END: begin
                    if (!bus_ack_i) begin
                        bus_req_o <= 1'b0;
                        state     <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // fragment fields and bus fields change only while req is low.
    always_ff @(posedge clk_i) begin
        case (state)
            S_IDLE: begin
                if (frag_valid_i) begin
                    idx_q       <= in_index;
                    depth_q     <= frag_depth_i;
                    color_q     <= frag_color_i;
                    bus_rw_o    <= BUS_READ;
                    bus_addr_o  <= depth_addr(in_index);
                    bus_wdata_o <= '0;
                end
            end
            S_RD_ACK: begin
                if (bus_ack_i) begin
                    stored_q <= bus_rdata_i;
                end
            end
            S_CHECK: begin
                bus_rw_o    <= BUS_WRITE;
                bus_addr_o  <= depth_addr(idx_q);
                bus_wdata_o <= depth_q;
            end
            S_WC_START: begin
                bus_addr_o  <= ADDR_WIDTH'(idx_q);
                bus_wdata_o <= {{(WORD_WIDTH - COLOR_WIDTH){1'b0}}, color_q};
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/mem_bank.sv
`default_nettype none

module mem_bank #(
    parameter type   data_t = logic [7:0],
    parameter int    DEPTH  = 64,
    parameter data_t FILL   = '0,
    localparam int   IDX_W  = $clog2(DEPTH)
) (
    input  wire              clk_i,
    input  wire              nrst_i,

    input  wire              en_i,
    input  wire              we_i,
    input  wire  [IDX_W-1:0] index_i,
    input  wire  data_t      wdata_i,
    output data_t            rdata_o
);

    data_t mem [DEPTH];

    // reset loads every entry with the fill value, so an untouched
    // depth buffer reads as far away and an untouched frame as black.
    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= FILL;
            end
        end else if (en_i && we_i) begin
            mem[index_i] <= wdata_i;
        end
    end

    // read data is valid in the cycle after en_i.
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            rdata_o <= mem[index_i];
        end
    end

endmodule

`default_nettype wire

//--- source/raster_pkg.sv
`default_nettype none

package raster_pkg;

    // width of one screen coordinate.
    localparam int SC_WIDTH = 4;

    // depth values and bus data share one word width.
    localparam int WORD_WIDTH = 16;

    localparam int COLOR_WIDTH = 8;

    localparam int ADDR_WIDTH = 16;

    // color bytes live below this address, one byte per pixel.
    // Depth words start here and are spaced four bytes apart.
    localparam logic [ADDR_WIDTH-1:0] DEPTH_BASE = 16'h0100;

    // direction of a bus transaction.
    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_rw_e;

    // payload of the depth bank.
    typedef logic [WORD_WIDTH-1:0] depth_t;

    // payload of the color bank.
    typedef logic [COLOR_WIDTH-1:0] color_t;

endpackage

`default_nettype wire
